// ==== build.f ====
design/cam_pkg.sv
design/dram_pkg.sv
design/sensor_powerup_seq.sv
design/dram_write_merge.sv
design/camera_board_top.sv
test/camera_board_assert.sv
test/camera_board_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the camera board testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=camera_board_tb
OBJ_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$("./$OBJ_DIR/V$TOP")
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== test/camera_board_tb.sv ====
module camera_board_tb
    import cam_pkg::*, dram_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = INIT_REQ_CYCLES + 2000;
    localparam int DONE_DELAY     = 20;

    // One cycle of merger stimulus with its expected write port
    typedef struct packed {
        logic     vid_data_we;
        wr_data_t vid_data;
        logic     vid_ctrl_we;
        wr_ctrl_t vid_ctrl;
        logic     dbg_data_level;
        wr_data_t dbg_data;
        logic     dbg_ctrl_level;
        wr_ctrl_t dbg_ctrl;
        logic     exp_data_we;
        wr_data_t exp_data;
        logic     exp_ctrl_we;
        wr_ctrl_t exp_ctrl;
    } stim_entry_t;

    logic                   clk125M;
    logic                   reset125M;
    logic [NUM_SENSORS-1:0] init_done_i;
    sensor_ctrl_t           sensor_ctrl_o;
    logic                   sensors_ready_o;
    wr_data_t               vid_data_i;
    logic                   vid_data_we_i;
    wr_ctrl_t               vid_ctrl_i;
    logic                   vid_ctrl_we_i;
    wr_data_t               dbg_data_i;
    logic                   dbg_data_level_i;
    wr_ctrl_t               dbg_ctrl_i;
    logic                   dbg_ctrl_level_i;
    wr_data_t               wr_data_o;
    logic                   wr_data_we_o;
    wr_ctrl_t               wr_ctrl_o;
    logic                   wr_ctrl_we_o;

    stim_entry_t stim_q[$];

    // Debug levels of the two previous table entries on each side
    logic data_lvl_1 = 1'b0;
    logic data_lvl_2 = 1'b0;
    logic ctrl_lvl_1 = 1'b0;
    logic ctrl_lvl_2 = 1'b0;

    int   edge_cnt    = 0;
    int   cycle_cnt   = 0;
    logic req_seen    = 1'b0;
    int   req_edge    = 0;
    logic done_lvl    = 1'b0;
    int   done_edge   = 0;
    int   data_errs   = 0;
    int   ctrl_errs   = 0;
    int   sensor_errs = 0;
    int   flag_errs   = 0;

    // Only sensor 0 reports init done
    assign init_done_i = {{(NUM_SENSORS-1){1'b0}}, done_lvl};

    camera_board_top dut (
        .clk125M          (clk125M),
        .reset125M        (reset125M),
        .init_done_i      (init_done_i),
        .sensor_ctrl_o    (sensor_ctrl_o),
        .sensors_ready_o  (sensors_ready_o),
        .vid_data_i       (vid_data_i),
        .vid_data_we_i    (vid_data_we_i),
        .vid_ctrl_i       (vid_ctrl_i),
        .vid_ctrl_we_i    (vid_ctrl_we_i),
        .dbg_data_i       (dbg_data_i),
        .dbg_data_level_i (dbg_data_level_i),
        .dbg_ctrl_i       (dbg_ctrl_i),
        .dbg_ctrl_level_i (dbg_ctrl_level_i),
        .wr_data_o        (wr_data_o),
        .wr_data_we_o     (wr_data_we_o),
        .wr_ctrl_o        (wr_ctrl_o),
        .wr_ctrl_we_o     (wr_ctrl_we_o)
    );

    bind camera_board_top camera_board_assert u_assert (
        .clk125M       (clk125M),
        .reset125M     (reset125M),
        .sensor_ctrl_i (sensor_ctrl_o),
        .wr_data_we_i  (wr_data_we_o),
        .wr_ctrl_we_i  (wr_ctrl_we_o)
    );

    always #4 clk125M = ~clk125M;

    // Edges since reset release
    always @(posedge clk125M) begin
        if (!reset125M) begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    always @(posedge clk125M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: sensors not ready after %0d clock cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // Sensor init engine answers a fixed delay after the request
    always @(negedge clk125M) begin : sensor_model
        if (edge_cnt != 0 && sensor_ctrl_o.init_req[0] && !req_seen) begin
            req_seen = 1'b1;
            req_edge = edge_cnt;
        end
        if (req_seen && !done_lvl && edge_cnt == req_edge + DONE_DELAY) begin
            done_lvl  = 1'b1;
            done_edge = edge_cnt;
        end
    end

    always @(negedge clk125M) begin : seq_monitor
        sensor_ctrl_t exp_ctrl;
        logic         pwup_on;
        logic         req_on;
        logic         exp_ready;
        if (edge_cnt != 0) begin
            pwup_on           = (edge_cnt >= PWUP_DELAY_CYCLES + 1);
            req_on            = (edge_cnt == INIT_REQ_CYCLES + 1);
            exp_ctrl.pwup     = {NUM_SENSORS{pwup_on}};
            exp_ctrl.init_req = {NUM_SENSORS{req_on}};
            exp_ready         = done_lvl && (edge_cnt >= done_edge + 1);
            check_sensor(sensor_ctrl_o, exp_ctrl);
            check_flag("sensors_ready_o", sensors_ready_o, exp_ready);
        end
    end

    task automatic check_data(input string what, input wr_data_t got, input wr_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ctrl(input string what, input wr_ctrl_t got, input wr_ctrl_t exp);
        if (got !== exp) begin
            ctrl_errs++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sensor(input sensor_ctrl_t got, input sensor_ctrl_t exp);
        if (got !== exp) begin
            sensor_errs++;
            $display("Fail %0t: sensor_ctrl_o pwup %b init_req %b, expected pwup %b init_req %b",
                     $time, got.pwup, got.init_req, exp.pwup, exp.init_req);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Appends one cycle and works out the expected write from the merge rule
    task automatic add_entry(input logic vd_we, input logic vc_we,
                             input logic dd_lvl, input logic dc_lvl);
        stim_entry_t e;
        logic        d_pulse;
        logic        c_pulse;
        e.vid_data_we    = vd_we;
        e.vid_data       = {$urandom(), 4'($urandom())};
        e.vid_ctrl_we    = vc_we;
        e.vid_ctrl       = {8'($urandom()), $urandom()};
        e.dbg_data_level = dd_lvl;
        e.dbg_data       = {$urandom(), 4'($urandom())};
        e.dbg_ctrl_level = dc_lvl;
        e.dbg_ctrl       = {8'($urandom()), $urandom()};
        d_pulse          = data_lvl_1 & ~data_lvl_2;
        c_pulse          = ctrl_lvl_1 & ~ctrl_lvl_2;
        e.exp_data_we    = vd_we | d_pulse;
        e.exp_data       = vd_we ? e.vid_data : e.dbg_data;
        e.exp_ctrl_we    = vc_we | c_pulse;
        e.exp_ctrl       = vc_we ? e.vid_ctrl : e.dbg_ctrl;
        data_lvl_2       = data_lvl_1;
        data_lvl_1       = dd_lvl;
        ctrl_lvl_2       = ctrl_lvl_1;
        ctrl_lvl_1       = dc_lvl;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        add_entry(0, 0, 0, 0);
        add_entry(0, 0, 0, 0);
        // Video strobe alone on each side and on both
        add_entry(1, 0, 0, 0);
        add_entry(0, 1, 0, 0);
        add_entry(1, 1, 0, 0);
        add_entry(0, 0, 0, 0);
        // Held debug levels and a second rise
        repeat (4) add_entry(0, 0, 1, 1);
        repeat (2) add_entry(0, 0, 0, 0);
        repeat (3) add_entry(0, 0, 1, 1);
        repeat (2) add_entry(0, 0, 0, 0);
        repeat (3) add_entry(0, 0, 0, 1);
        repeat (2) add_entry(0, 0, 0, 0);
        // Video strobe lands on the debug pulse
        add_entry(0, 0, 1, 1);
        add_entry(1, 1, 1, 1);
        add_entry(0, 0, 1, 1);
        repeat (2) add_entry(0, 0, 0, 0);
        repeat (24) begin
            add_entry(($urandom() % 4) == 0, ($urandom() % 4) == 0,
                      ($urandom() % 3) != 0, ($urandom() % 3) != 0);
        end
        add_entry(0, 0, 0, 0);
    endtask

    task automatic apply_entry(input stim_entry_t e);
        vid_data_i       = e.vid_data;
        vid_data_we_i    = e.vid_data_we;
        vid_ctrl_i       = e.vid_ctrl;
        vid_ctrl_we_i    = e.vid_ctrl_we;
        dbg_data_i       = e.dbg_data;
        dbg_data_level_i = e.dbg_data_level;
        dbg_ctrl_i       = e.dbg_ctrl;
        dbg_ctrl_level_i = e.dbg_ctrl_level;
    endtask

    task automatic drive_idle();
        vid_data_i       = '0;
        vid_data_we_i    = 1'b0;
        vid_ctrl_i       = '0;
        vid_ctrl_we_i    = 1'b0;
        dbg_data_i       = '0;
        dbg_data_level_i = 1'b0;
        dbg_ctrl_i       = '0;
        dbg_ctrl_level_i = 1'b0;
    endtask

    task automatic check_entry(input stim_entry_t e, input int idx);
        check_flag($sformatf("wr_data_we_o entry %0d", idx), wr_data_we_o, e.exp_data_we);
        check_flag($sformatf("wr_ctrl_we_o entry %0d", idx), wr_ctrl_we_o, e.exp_ctrl_we);
        check_data($sformatf("wr_data_o entry %0d", idx), wr_data_o, e.exp_data);
        check_ctrl($sformatf("wr_ctrl_o entry %0d", idx), wr_ctrl_o, e.exp_ctrl);
    endtask

    initial begin
        int total;
        void'($urandom(32'h3fdd));
        clk125M   = 1'b0;
        reset125M = 1'b1;
        drive_idle();
        // Console levels stay high through reset
        dbg_data_level_i = 1'b1;
        dbg_ctrl_level_i = 1'b1;
        build_table();
        repeat (8) @(negedge clk125M);
        reset125M = 1'b0;
        drive_idle();

        foreach (stim_q[i]) begin
            @(negedge clk125M);
            apply_entry(stim_q[i]);
            #1;
            check_entry(stim_q[i], i);
        end
        @(negedge clk125M);
        drive_idle();

        // Sequencer runs to the end of its 2 ms init phase
        while (!sensors_ready_o) begin
            @(negedge clk125M);
        end
        repeat (50) @(negedge clk125M);

        total = data_errs + ctrl_errs + sensor_errs + flag_errs;
        $display("Error counts: data %0d, ctrl %0d, sensor %0d, flag %0d",
                 data_errs, ctrl_errs, sensor_errs, flag_errs);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== test/camera_board_assert.sv ====
module camera_board_assert
    import cam_pkg::*;
(
    input logic         clk125M,
    input logic         reset125M,
    input sensor_ctrl_t sensor_ctrl_i,
    input logic         wr_data_we_i,
    input logic         wr_ctrl_we_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Init request is a single-cycle strobe
    property init_req_single;
        @(posedge clk125M) disable iff (reset125M)
            (sensor_ctrl_i.init_req != '0) |=> (sensor_ctrl_i.init_req == '0);
    endproperty

    // A power line once raised stays raised
    property pwup_no_fall;
        @(posedge clk125M) disable iff (reset125M)
            ((sensor_ctrl_i.pwup & $past(sensor_ctrl_i.pwup)) == $past(sensor_ctrl_i.pwup));
    endproperty

    // Debug pulse registers come out of reset cleared
    property strobes_low_after_reset;
        @(posedge clk125M)
            $fell(reset125M) |-> (!wr_data_we_i && !wr_ctrl_we_i);
    endproperty

    init_req_single_a: assert property (init_req_single)
        else $error("init request held high for two cycles in a row");

    pwup_no_fall_a: assert property (pwup_no_fall)
        else $error("sensor power-up line dropped outside reset");

    strobes_low_after_reset_a: assert property (strobes_low_after_reset)
        else $error("DRAM write strobe high in the first cycle after reset");

endmodule

// ==== design/camera_board_top.sv ====
module camera_board_top
    import cam_pkg::*, dram_pkg::*;
(
    input  logic                   clk125M,
    input  logic                   reset125M,

    // Sensor power and init
    input  logic [NUM_SENSORS-1:0] init_done_i,
    output sensor_ctrl_t           sensor_ctrl_o,
    output logic                   sensors_ready_o,

    // Video write requests
    input  wr_data_t               vid_data_i,
    input  logic                   vid_data_we_i,
    input  wr_ctrl_t               vid_ctrl_i,
    input  logic                   vid_ctrl_we_i,

    // Debug console write requests
    input  wr_data_t               dbg_data_i,
    input  logic                   dbg_data_level_i,
    input  wr_ctrl_t               dbg_ctrl_i,
    input  logic                   dbg_ctrl_level_i,

    // DRAM write engine port
    output wr_data_t               wr_data_o,
    output logic                   wr_data_we_o,
    output wr_ctrl_t               wr_ctrl_o,
    output logic                   wr_ctrl_we_o
);

    sensor_powerup_seq u_sensor_powerup_seq (
        .clk125M         (clk125M),
        .reset125M       (reset125M),
        .init_done_i     (init_done_i),
        .sensor_ctrl_o   (sensor_ctrl_o),
        .sensors_ready_o (sensors_ready_o)
    );

    dram_write_merge u_dram_write_merge (
        .clk125M          (clk125M),
        .reset125M        (reset125M),
        .vid_data_i       (vid_data_i),
        .vid_data_we_i    (vid_data_we_i),
        .vid_ctrl_i       (vid_ctrl_i),
        .vid_ctrl_we_i    (vid_ctrl_we_i),
        .dbg_data_i       (dbg_data_i),
        .dbg_data_level_i (dbg_data_level_i),
        .dbg_ctrl_i       (dbg_ctrl_i),
        .dbg_ctrl_level_i (dbg_ctrl_level_i),
        .wr_data_o        (wr_data_o),
        .wr_data_we_o     (wr_data_we_o),
        .wr_ctrl_o        (wr_ctrl_o),
        .wr_ctrl_we_o     (wr_ctrl_we_o)
    );

endmodule

// ==== design/dram_write_merge.sv ====
module dram_write_merge
    import dram_pkg::*;
(
    input  logic     clk125M,
    input  logic     reset125M,

    // Video capture path, strobes are single-cycle
    input  wr_data_t vid_data_i,
    input  logic     vid_data_we_i,
    input  wr_ctrl_t vid_ctrl_i,
    input  logic     vid_ctrl_we_i,

    // Debug console, write enables are levels
    input  wr_data_t dbg_data_i,
    input  logic     dbg_data_level_i,
    input  wr_ctrl_t dbg_ctrl_i,
    input  logic     dbg_ctrl_level_i,

    // Toward the DRAM write engine
    output wr_data_t wr_data_o,
    output logic     wr_data_we_o,
    output wr_ctrl_t wr_ctrl_o,
    output logic     wr_ctrl_we_o
);

    logic dbg_data_level_d;
    logic dbg_ctrl_level_d;
    logic dbg_data_pulse;
    logic dbg_ctrl_pulse;

    // Previous samples of the console levels
    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            dbg_data_level_d <= 1'b0;
            dbg_ctrl_level_d <= 1'b0;
        end else begin
            dbg_data_level_d <= dbg_data_level_i;
            dbg_ctrl_level_d <= dbg_ctrl_level_i;
        end
    end

    // Rising edge of each level becomes a one-cycle write
    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            dbg_data_pulse <= 1'b0;
            dbg_ctrl_pulse <= 1'b0;
        end else begin
            dbg_data_pulse <= dbg_data_level_i & ~dbg_data_level_d;
            dbg_ctrl_pulse <= dbg_ctrl_level_i & ~dbg_ctrl_level_d;
        end
    end

    // Video wins, a colliding debug write is dropped
    always_comb begin
        if (vid_data_we_i) begin
            wr_data_o = vid_data_i;
        end else begin
            wr_data_o = dbg_data_i;
        end
        wr_data_we_o = vid_data_we_i | dbg_data_pulse;
    end

    always_comb begin
        if (vid_ctrl_we_i) begin
            wr_ctrl_o = vid_ctrl_i;
        end else begin
            wr_ctrl_o = dbg_ctrl_i;
        end
        wr_ctrl_we_o = vid_ctrl_we_i | dbg_ctrl_pulse;
    end

endmodule

// ==== design/sensor_powerup_seq.sv ====
module sensor_powerup_seq
    import cam_pkg::*;
(
    input  logic                   clk125M,
    input  logic                   reset125M,
    input  logic [NUM_SENSORS-1:0] init_done_i,
    output sensor_ctrl_t           sensor_ctrl_o,
    output logic                   sensors_ready_o
);

    typedef enum logic [1:0] {
        wait_pwup,
        wait_init,
        wait_done,
        ready
    } seq_state_t;

    seq_state_t  state;
    logic [31:0] cycle_cnt;
    logic        pwup_hit;
    logic        init_hit;
    logic        cnt_run;

    assign pwup_hit = (cycle_cnt == PWUP_DELAY_CYCLES);
    assign init_hit = (cycle_cnt == INIT_REQ_CYCLES);

    // Counter freezes once the init request is out
    assign cnt_run = (state == wait_pwup) || (state == wait_init);

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            cycle_cnt <= '0;
        end else if (cnt_run) begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            state <= wait_pwup;
        end else begin
            unique case (state)
                wait_pwup: begin
                    if (pwup_hit) begin
                        state <= wait_init;
                    end
                end
                wait_init: begin
                    if (init_hit) begin
                        state <= wait_done;
                    end
                end
                wait_done: begin
                    // Only sensor 0 reports completion
                    if (init_done_i[0]) begin
                        state <= ready;
                    end
                end
                ready: begin
                    state <= ready;
                end
                default: begin
                    state <= wait_pwup;
                end
            endcase
        end
    end

    // Power lines latch on at 1 ms and stay on
    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            sensor_ctrl_o.pwup <= '0;
        end else if (state == wait_pwup && pwup_hit) begin
            sensor_ctrl_o.pwup <= '1;
        end
    end

    // One-cycle request on the wait_init to wait_done step
    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            sensor_ctrl_o.init_req <= '0;
        end else if (state == wait_init && init_hit) begin
            sensor_ctrl_o.init_req <= '1;
        end else begin
            sensor_ctrl_o.init_req <= '0;
        end
    end

    assign sensors_ready_o = (state == ready);

endmodule

// ==== design/dram_pkg.sv ====
package dram_pkg;

    // Write data channel widths
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Write command widths
    localparam int ADDR_W = 32;
    localparam int LEN_W  = 8;

    // Data word with its byte enables in the low bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_data_t;

    // Burst length on top, start address below
    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } wr_ctrl_t;

endpackage

// ==== design/cam_pkg.sv ====
package cam_pkg;

    // Both image sensors share one power-up sequence
    localparam int NUM_SENSORS = 2;

    // Sequencer checkpoints in clk125M cycles after reset release

    // 1 ms
    localparam logic [31:0] PWUP_DELAY_CYCLES = 32'd125000;

    // 2 ms
    localparam logic [31:0] INIT_REQ_CYCLES = 32'd250000;

    // Per-sensor control lines, one bit per sensor in each field
    typedef struct packed {
        logic [NUM_SENSORS-1:0] pwup;
        logic [NUM_SENSORS-1:0] init_req;
    } sensor_ctrl_t;

endpackage
